//--- histMacros_macros.svh
`ifndef HIST_MACROS_SVH
`define HIST_MACROS_SVH

// raw time-to-digital code
`define TDC_WIDTH 10

// low code bits dropped when forming a bin
`define BIN_SHIFT 4

// bin index width, code width minus shift
`define BIN_ADDR_WIDTH 6

// bins per histogram
`define BIN_NUM 64

// per-bin counter, saturates at all ones
`define COUNT_WIDTH 8

// dropped-hit counter, wraps
`define DROP_WIDTH 16

`endif

//--- histTypesPkg.sv
`default_nettype none

`include "histMacros_macros.svh"

package histTypesPkg;

    // raw code as it comes from the TDC
    typedef logic [`TDC_WIDTH-1:0] tdcCode_t;

    // histogram bin index
    typedef logic [`BIN_ADDR_WIDTH-1:0] binAddr_t;

    // hit count of one bin
    typedef logic [`COUNT_WIDTH-1:0] binCount_t;

    // hits lost while a sweep runs
    typedef logic [`DROP_WIDTH-1:0] dropCount_t;

endpackage

`default_nettype wire

//--- histCtrlPkg.sv
`default_nettype none

package histCtrlPkg;

    // builder phases
    // flush clears the RAM once after reset
    typedef enum logic [2:0] {
        IDLE,
        ACCUM,
        DRAIN,
        SWEEP,
        FLUSH
    } builderState_t;

endpackage

`default_nettype wire

//--- hitCapture.sv
`default_nettype none

`include "histMacros_macros.svh"

module hitCapture (
    input  wire                      clk,
    input  wire                      res,
    input  wire                      hit,
    input  wire histTypesPkg::tdcCode_t tdcCode,
    input  wire                      frameEnd,
    input  wire                      busy,
    output logic                     binStrobe,
    output histTypesPkg::binAddr_t   binAddr,
    output logic                     sweepReq,
    output histTypesPkg::dropCount_t droppedHits
);

    // control side, strobes and drop counter
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binStrobe   <= 1'b0;
            sweepReq    <= 1'b0;
            droppedHits <= '0;
        end else begin
            // hits only pass while no sweep runs
            binStrobe <= hit && !busy;
            // frame end during busy is ignored
            sweepReq  <= frameEnd && !busy;
            // lost hit, counter simply wraps
            if (hit && busy) begin
                droppedHits <= droppedHits + 1'b1;
            end
        end
    end

    // bin index is the upper part of the code
    // fine bits below BIN_SHIFT are dropped
    always_ff @(posedge clk) begin
        binAddr <= tdcCode[`TDC_WIDTH-1:`BIN_SHIFT];
    end

endmodule

`default_nettype wire

//--- histRam.sv
`default_nettype none

`include "histMacros_macros.svh"

module histRam (
    input  wire                       clk,
    input  wire                       wEnable,
    input  wire histTypesPkg::binAddr_t  waddr,
    input  wire histTypesPkg::binCount_t wdata,
    input  wire                       rEnable,
    input  wire histTypesPkg::binAddr_t  raddr,
    output histTypesPkg::binCount_t   rdata
);

    // one count per bin
    histTypesPkg::binCount_t mem [`BIN_NUM];

    // write port
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, same address as a write gives old data
    always_ff @(posedge clk) begin
        if (rEnable) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- histBuilder.sv
`default_nettype none

`include "histMacros_macros.svh"

module histBuilder (
    input  wire                       clk,
    input  wire                       res,
    input  wire                       binStrobe,
    input  wire histTypesPkg::binAddr_t  binAddr,
    input  wire                       sweepReq,
    output logic                      busy,
    output logic                      wEnable,
    output histTypesPkg::binAddr_t    waddr,
    output histTypesPkg::binCount_t   wdata,
    output logic                      rEnable,
    output histTypesPkg::binAddr_t    raddr,
    input  wire histTypesPkg::binCount_t rdata,
    output histTypesPkg::binCount_t   binStream,
    output histTypesPkg::binAddr_t    binStreamIdx,
    output logic                      binStreamValid,
    output logic                      binStreamLast
);

    histCtrlPkg::builderState_t state;
    histCtrlPkg::builderState_t nextState;

    // bin counter for flush and sweep
    histTypesPkg::binAddr_t sweepIdx;
    logic idxLast;
    logic acceptHit;
    logic clearing;

    // stage 1, read data returns
    logic s1Valid;
    histTypesPkg::binAddr_t s1Addr;

    // stage 2, pending write
    logic w2Valid;
    histTypesPkg::binAddr_t w2Addr;
    histTypesPkg::binCount_t w2Data;

    // stage 3, write that landed while a newer read was issued
    logic s3Valid;
    histTypesPkg::binAddr_t s3Addr;
    histTypesPkg::binCount_t s3Data;

    histTypesPkg::binCount_t baseCount;
    histTypesPkg::binCount_t nextCount;

    // sweep read tracking
    logic rdValid;
    logic rdLast;
    histTypesPkg::binAddr_t rdIdx;

    assign idxLast   = (sweepIdx == `BIN_ADDR_WIDTH'(`BIN_NUM - 1));
    // late hit still comes in during the first drain cycle
    assign acceptHit = binStrobe && (state == histCtrlPkg::ACCUM ||
                                     state == histCtrlPkg::DRAIN);
    assign clearing  = (state == histCtrlPkg::SWEEP) || (state == histCtrlPkg::FLUSH);

    always_comb begin
        nextState = state;
        case (state)
            histCtrlPkg::IDLE:  nextState = histCtrlPkg::FLUSH;
            histCtrlPkg::FLUSH: if (idxLast) nextState = histCtrlPkg::ACCUM;
            histCtrlPkg::ACCUM: if (sweepReq) nextState = histCtrlPkg::DRAIN;
            // writes of the last hit finish before the first sweep read
            histCtrlPkg::DRAIN: if (!binStrobe && !s1Valid) nextState = histCtrlPkg::SWEEP;
            histCtrlPkg::SWEEP: if (idxLast) nextState = histCtrlPkg::ACCUM;
            default:            nextState = histCtrlPkg::IDLE;
        endcase
    end

    // read port, hit lookup or sweep scan
    assign rEnable = acceptHit || (state == histCtrlPkg::SWEEP);
    assign raddr   = (state == histCtrlPkg::SWEEP) ? sweepIdx : binAddr;

    // write port, incremented count or zero while clearing
    assign wEnable = w2Valid || clearing;
    assign waddr   = clearing ? sweepIdx : w2Addr;
    assign wdata   = clearing ? '0 : w2Data;

    // forwarding, newest pending write wins
    always_comb begin
        if (w2Valid && (w2Addr == s1Addr)) begin
            baseCount = w2Data;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            baseCount = s3Data;
        end else begin
            baseCount = rdata;
        end
        // saturate at all ones
        if (baseCount == '1) begin
            nextCount = baseCount;
        end else begin
            nextCount = baseCount + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= histCtrlPkg::IDLE;
            sweepIdx <= '0;
            s1Valid  <= 1'b0;
            w2Valid  <= 1'b0;
            s3Valid  <= 1'b0;
            rdValid  <= 1'b0;
            rdLast   <= 1'b0;
            busy     <= 1'b0;
        end else begin
            state   <= nextState;
            s1Valid <= acceptHit;
            w2Valid <= s1Valid;
            s3Valid <= w2Valid;
            rdValid <= (state == histCtrlPkg::SWEEP);
            rdLast  <= (state == histCtrlPkg::SWEEP) && idxLast;
            // wraps back to 0 after the last bin
            if (clearing) begin
                sweepIdx <= sweepIdx + 1'b1;
            end else begin
                sweepIdx <= '0;
            end
            // busy drops together with peakValid
            if (state == histCtrlPkg::IDLE ||
                (state == histCtrlPkg::ACCUM && sweepReq)) begin
                busy <= 1'b1;
            end else if ((state == histCtrlPkg::FLUSH && idxLast) || rdLast) begin
                busy <= 1'b0;
            end
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        s1Addr <= binAddr;
        w2Addr <= s1Addr;
        w2Data <= nextCount;
        s3Addr <= w2Addr;
        s3Data <= w2Data;
        rdIdx  <= sweepIdx;
    end

    // swept counts come straight from the read port
    assign binStream      = rdata;
    assign binStreamIdx   = rdIdx;
    assign binStreamValid = rdValid;
    assign binStreamLast  = rdLast;

endmodule

`default_nettype wire

//--- peakFinder.sv
`default_nettype none

module peakFinder (
    input  wire                       clk,
    input  wire                       res,
    input  wire histTypesPkg::binCount_t binStream,
    input  wire histTypesPkg::binAddr_t  binStreamIdx,
    input  wire                       binStreamValid,
    input  wire                       binStreamLast,
    output logic                      peakValid,
    output histTypesPkg::binAddr_t    peakBin,
    output histTypesPkg::binCount_t   peakCount
);

    // running maximum of the current sweep
    histTypesPkg::binAddr_t  runBin;
    histTypesPkg::binCount_t runCount;
    logic takeBin;
    histTypesPkg::binAddr_t  nextBin;
    histTypesPkg::binCount_t nextCount;

    // bin 0 restarts the scan, strictly greater keeps ties low
    assign takeBin   = (binStreamIdx == '0) || (binStream > runCount);
    assign nextBin   = takeBin ? binStreamIdx : runBin;
    assign nextCount = takeBin ? binStream : runCount;

    always_ff @(posedge clk) begin
        if (binStreamValid) begin
            runBin   <= nextBin;
            runCount <= nextCount;
        end
    end

    // result held until the next sweep ends
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid <= 1'b0;
            peakBin   <= '0;
            peakCount <= '0;
        end else begin
            peakValid <= binStreamValid && binStreamLast;
            if (binStreamValid && binStreamLast) begin
                peakBin   <= nextBin;
                peakCount <= nextCount;
            end
        end
    end

endmodule

`default_nettype wire

//--- histTop.sv
`default_nettype none

module histTop (
    input  wire                       clk,
    input  wire                       res,
    input  wire                       hit,
    input  wire histTypesPkg::tdcCode_t  tdcCode,
    input  wire                       frameEnd,
    output wire                       busy,
    output histTypesPkg::dropCount_t  droppedHits,
    output wire                       peakValid,
    output histTypesPkg::binAddr_t    peakBin,
    output histTypesPkg::binCount_t   peakCount
);

    // capture to builder
    wire binStrobe;
    wire sweepReq;
    histTypesPkg::binAddr_t binAddr;

    // builder to RAM
    wire wEnable;
    wire rEnable;
    histTypesPkg::binAddr_t  waddr;
    histTypesPkg::binAddr_t  raddr;
    histTypesPkg::binCount_t wdata;
    histTypesPkg::binCount_t rdata;

    // swept bins to peak search
    histTypesPkg::binCount_t binStream;
    histTypesPkg::binAddr_t  binStreamIdx;
    wire binStreamValid;
    wire binStreamLast;

    hitCapture i_hitCapture (
        .clk(clk), .res(res), .hit(hit), .tdcCode(tdcCode), .frameEnd(frameEnd),
        .busy(busy), .binStrobe(binStrobe), .binAddr(binAddr), .sweepReq(sweepReq),
        .droppedHits(droppedHits)
    );

    histBuilder i_histBuilder (
        .clk(clk), .res(res), .binStrobe(binStrobe), .binAddr(binAddr),
        .sweepReq(sweepReq), .busy(busy), .wEnable(wEnable), .waddr(waddr),
        .wdata(wdata), .rEnable(rEnable), .raddr(raddr), .rdata(rdata),
        .binStream(binStream), .binStreamIdx(binStreamIdx),
        .binStreamValid(binStreamValid), .binStreamLast(binStreamLast)
    );

    histRam i_histRam (
        .clk(clk), .wEnable(wEnable), .waddr(waddr), .wdata(wdata),
        .rEnable(rEnable), .raddr(raddr), .rdata(rdata)
    );

    peakFinder i_peakFinder (
        .clk(clk), .res(res), .binStream(binStream), .binStreamIdx(binStreamIdx),
        .binStreamValid(binStreamValid), .binStreamLast(binStreamLast),
        .peakValid(peakValid), .peakBin(peakBin), .peakCount(peakCount)
    );

endmodule

`default_nettype wire

//--- histTb.sv
`default_nettype none

`include "histMacros_macros.svh"

module histTb;

    logic clk = 1'b0;
    logic res;
    logic hit;
    logic frameEnd;
    histTypesPkg::tdcCode_t tdcCode;
    wire busy;
    wire peakValid;
    histTypesPkg::dropCount_t droppedHits;
    histTypesPkg::binAddr_t peakBin;
    histTypesPkg::binCount_t peakCount;

    // reference histogram with one count per bin
    int refBins [`BIN_NUM];
    int expDropped = 0;
    int errCount = 0;
    int timeouts = 0;
    integer seed = 32'h9ef7_d704;
    logic [31:0] r;
    histTypesPkg::tdcCode_t code;

    histTop i_dut (
        .clk(clk), .res(res), .hit(hit), .tdcCode(tdcCode), .frameEnd(frameEnd),
        .busy(busy), .droppedHits(droppedHits), .peakValid(peakValid),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    always #5 clk = ~clk;

    task automatic checkValue(input int got, input int exp, input string what);
        assert (got == exp) else begin
            errCount++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            hit = 1'b0;
            frameEnd = 1'b0;
        end
    endtask

    // one hit per call so consecutive calls give back-to-back hits
    task automatic sendHit(input histTypesPkg::tdcCode_t hitCode);
        int bin;
        @(negedge clk);
        hit = 1'b1;
        frameEnd = 1'b0;
        tdcCode = hitCode;
        bin = int'(hitCode >> `BIN_SHIFT);
        // busy here is the value the capture stage samples next edge
        if (busy) begin
            expDropped++;
        end else if (refBins[bin] < (1 << `COUNT_WIDTH) - 1) begin
            refBins[bin]++;
        end
    endtask

    // n hits into one bin with varying fine bits
    task automatic hitBin(input int bin, input int n);
        int fine;
        for (int i = 0; i < n; i++) begin
            fine = i % (1 << `BIN_SHIFT);
            sendHit(histTypesPkg::tdcCode_t'((bin << `BIN_SHIFT) + fine));
        end
    endtask

    task automatic pulseFrameEnd();
        @(negedge clk);
        hit = 1'b0;
        frameEnd = 1'b1;
        @(negedge clk);
        frameEnd = 1'b0;
    endtask

    task automatic waitBusy(input bit level, input int limit, input string what);
        int n;
        if (timeouts == 0) begin
            n = 0;
            while (busy !== level && n < limit) begin
                @(negedge clk);
                n++;
            end
            if (busy !== level) begin
                $display("timeout, busy never became %0d at %s", level, what);
                timeouts++;
            end
        end
    endtask

    // expected peak from the model and then the DUT result
    task automatic collectPeak();
        int expBin;
        int expCount;
        int n;
        expBin = 0;
        expCount = 0;
        // strictly greater keeps the lowest bin on a tie
        for (int b = 0; b < `BIN_NUM; b++) begin
            if (refBins[b] > expCount) begin
                expBin = b;
                expCount = refBins[b];
            end
        end
        n = 0;
        while (!peakValid && n < 400 && timeouts == 0) begin
            @(negedge clk);
            n++;
        end
        if (peakValid) begin
            checkValue(int'(peakBin), expBin, "peakBin");
            checkValue(int'(peakCount), expCount, "peakCount");
            checkValue(int'(busy), 0, "busy at peakValid");
        end else if (timeouts == 0) begin
            $display("timeout, no peakValid within 400 cycles of frame end");
            timeouts++;
        end
        // sweep clears every bin
        foreach (refBins[b]) refBins[b] = 0;
    endtask

    initial begin
        res = 1'b0;
        hit = 1'b0;
        frameEnd = 1'b0;
        tdcCode = '0;
        code = '0;
        foreach (refBins[b]) refBins[b] = 0;
        repeat (5) @(negedge clk);
        res = 1'b1;
        checkValue(int'(peakValid), 0, "peakValid after reset");
        checkValue(int'(peakBin), 0, "peakBin after reset");
        checkValue(int'(peakCount), 0, "peakCount after reset");
        checkValue(int'(droppedHits), 0, "droppedHits after reset");
        // RAM flush runs with busy high
        waitBusy(1'b1, 10, "flush start");
        waitBusy(1'b0, 200, "flush end");

        // empty frame
        pulseFrameEnd();
        collectPeak();

        // random frame where half the codes crowd into bins 0 to 7
        for (int i = 0; i < 150; i++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                idleCycles(1);
            end else if (r[3:2] == 2'b00) begin
                // same code again back to back
                sendHit(code);
            end else begin
                code = r[13:4];
                if (r[14]) begin
                    code[9:7] = 3'b000;
                end
                sendHit(code);
            end
        end
        pulseFrameEnd();
        collectPeak();

        // single hit after a sweep
        hitBin(9, 1);
        pulseFrameEnd();
        collectPeak();

        // saturation at all ones
        hitBin(17, 300);
        pulseFrameEnd();
        collectPeak();

        // tie with the higher bin filled first
        hitBin(40, 3);
        idleCycles(2);
        hitBin(12, 3);
        pulseFrameEnd();
        collectPeak();

        // hits and a second frame end while the sweep runs
        hitBin(33, 5);
        hitBin(50, 2);
        pulseFrameEnd();
        waitBusy(1'b1, 10, "sweep start");
        for (int i = 0; i < 12; i++) begin
            sendHit(histTypesPkg::tdcCode_t'(60 << `BIN_SHIFT));
            frameEnd = (i == 6);
        end
        idleCycles(1);
        collectPeak();
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            checkValue(int'(peakValid), 0, "peakValid after ignored frame end");
        end
        checkValue(int'(droppedHits), expDropped, "droppedHits");
        // dropped hits must not show up in bin 60
        hitBin(3, 2);
        pulseFrameEnd();
        collectPeak();

        idleCycles(5);
        $display("failed checks: %0d, timeouts: %0d", errCount, timeouts);
        if (errCount == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
histTypesPkg.sv
histCtrlPkg.sv
hitCapture.sv
histRam.sv
histBuilder.sv
peakFinder.sv
histTop.sv
histTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module histTb -f flist.f

simOut=$(./obj_dir/VhistTb)
echo "$simOut"

if echo "$simOut" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi
